// ==== hdl/command_decoder.sv ====
`timescale 1ns/1ns

module command_decoder (
	input  logic                clock,
	input  logic                reset_n,
	input  logic                byte_ready,
	input  logic [7:0]          byte_data,
	output logic                cmd_received,
	output sump_pkg::sump_cmd_t cmd
);
	typedef enum logic [2:0] {
		idle,
		check_op,
		wait_byte,
		byte_written,
		done
	} state_t;

	state_t state;
	state_t next_state;
	logic [7:0] opcode;
	logic op_we;
	logic shift_we;
	logic shift_clr;
	logic shift_full;
	logic load_cmd;
	sump_pkg::sump_payload_u payload;

	command_shift command_shift_inst (
		.clock   (clock),
		.reset_n (reset_n),
		.clr     (shift_clr),
		.we      (shift_we),
		.byte_in (byte_data),
		.full    (shift_full),
		.payload (payload)
	);

	assign cmd_received = (state == done);
	assign shift_clr    = (state == idle); // Payload stays zero for short commands

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			opcode <= '0;
		end else if (op_we) begin
			opcode <= byte_data;
		end
	end

	// Held until the next command completes
	always_ff @(posedge clock) begin
		if (!reset_n) begin
			cmd <= '0;
		end else if (load_cmd) begin
			cmd.opcode  <= opcode;
			cmd.payload <= payload;
		end
	end

	always_comb begin
		next_state = state;
		op_we      = 1'b0;
		shift_we   = 1'b0;
		load_cmd   = 1'b0;
		case (state)
			idle: begin
				if (byte_ready) begin
					op_we      = 1'b1;
					next_state = check_op;
				end
			end
			check_op: begin
				if (!byte_ready) begin // Strobe has dropped
					if (opcode[sump_pkg::LONG_BIT]) begin
						next_state = wait_byte;
					end else begin
						load_cmd   = 1'b1;
						next_state = done;
					end
				end
			end
			wait_byte: begin
				if (byte_ready) begin
					shift_we   = 1'b1;
					next_state = byte_written;
				end
			end
			byte_written: begin
				if (shift_full) begin
					load_cmd   = 1'b1;
					next_state = done;
				end else if (!byte_ready) begin
					next_state = wait_byte;
				end
			end
			done: next_state = idle;
			default: next_state = idle;
		endcase
	end

endmodule

// ==== hdl/command_shift.sv ====
`timescale 1ns/1ns

module command_shift (
	input  logic                    clock,
	input  logic                    reset_n,
	input  logic                    clr,
	input  logic                    we,
	input  logic [7:0]              byte_in,
	output logic                    full,
	output sump_pkg::sump_payload_u payload
);
	logic [2:0] count;
	logic [7:0] bytes [0:3];

	assign full = count[2]; // Four bytes written
	assign payload.raw = {bytes[0], bytes[1], bytes[2], bytes[3]};

	always_ff @(posedge clock) begin
		if (!reset_n || clr) begin
			for (int i = 0; i < 4; i++) begin
				bytes[i] <= '0;
			end
			count <= '0;
		end else if (we) begin
			bytes[count[1:0]] <= byte_in;
			count <= count + 3'd1;
		end
	end

endmodule

// ==== hdl/sump_control.sv ====
`timescale 1ns/1ns

module sump_control (
	input  logic                clock,
	input  logic                reset_n,
	input  logic                cmd_received,
	input  sump_pkg::sump_cmd_t cmd,
	input  logic [7:0]          probe,
	input  logic                tx_ready,
	output logic                tx_valid,
	output logic [7:0]          tx_data,
	output logic                armed,
	output logic                triggered,
	output logic [23:0]         divider,
	output logic [7:0]          trigger_mask,
	output logic [7:0]          trigger_value
);
	logic [1:0] reply_idx;
	logic reply_busy;
	logic hit;

	assign hit      = ((probe ^ trigger_value) & trigger_mask) == 8'h00; // Masked bits equal
	assign tx_valid = reply_busy;
	assign tx_data  = sump_pkg::ID_WORD[31 - 8 * reply_idx -: 8];

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			divider       <= '0;
			trigger_mask  <= '0;
			trigger_value <= '0;
		end else if (cmd_received) begin
			case (cmd.opcode)
				sump_pkg::OP_SET_DIVIDER:   divider       <= cmd.payload.divider_view.divider;
				sump_pkg::OP_TRIGGER_MASK:  trigger_mask  <= cmd.payload.pattern_view.pattern;
				sump_pkg::OP_TRIGGER_VALUE: trigger_value <= cmd.payload.pattern_view.pattern;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			armed     <= 1'b0;
			triggered <= 1'b0;
		end else begin
			if (armed && hit) begin
				armed     <= 1'b0;
				triggered <= 1'b1;
			end
			if (cmd_received && cmd.opcode == sump_pkg::OP_RESET) begin
				armed     <= 1'b0; // Configuration is kept
				triggered <= 1'b0;
			end else if (cmd_received && cmd.opcode == sump_pkg::OP_ARM) begin
				armed     <= 1'b1;
				triggered <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			reply_busy <= 1'b0;
			reply_idx  <= '0;
		end else if (reply_busy) begin
			if (tx_ready) begin
				reply_idx <= reply_idx + 2'd1;
				if (reply_idx == 2'd3) begin
					reply_busy <= 1'b0;
				end
			end
		end else if (cmd_received && cmd.opcode == sump_pkg::OP_ID) begin
			reply_busy <= 1'b1; // Repeat ID ignored while busy
			reply_idx  <= '0;
		end
	end

endmodule

// ==== hdl/sump_pkg.sv ====
package sump_pkg;

	localparam logic [7:0] OP_RESET         = 8'h00;
	localparam logic [7:0] OP_ARM           = 8'h01;
	localparam logic [7:0] OP_ID            = 8'h02;
	localparam logic [7:0] OP_SET_DIVIDER   = 8'h80;
	localparam logic [7:0] OP_TRIGGER_MASK  = 8'hc0;
	localparam logic [7:0] OP_TRIGGER_VALUE = 8'hc1;

	localparam int LONG_BIT = 7; // Set on opcodes with four payload bytes

	localparam logic [31:0] ID_WORD = "1ALS"; // Top byte goes out first

	typedef struct packed {
		logic [7:0]  reserved;
		logic [23:0] divider;
	} divider_view_t;

	typedef struct packed {
		logic [23:0] reserved;
		logic [7:0]  pattern; // Last byte received
	} pattern_view_t;

	// First payload byte received sits in the top byte
	typedef union packed {
		logic [31:0]   raw;
		divider_view_t divider_view;
		pattern_view_t pattern_view;
	} sump_payload_u;

	typedef struct packed {
		logic [7:0]    opcode;
		sump_payload_u payload; // Zero for short commands
	} sump_cmd_t;

endpackage

// ==== hdl/sump_top.sv ====
`timescale 1ns/1ns

module sump_top #(
	parameter int clks_per_bit = 4
) (
	input  logic        clock,
	input  logic        reset_n,
	input  logic        rx,
	output logic        tx,
	input  logic [7:0]  probe,
	output logic        armed,
	output logic        triggered,
	output logic [23:0] divider,
	output logic [7:0]  trigger_mask,
	output logic [7:0]  trigger_value
);
	logic byte_ready;
	logic [7:0] byte_data;
	logic cmd_received;
	sump_pkg::sump_cmd_t cmd;
	logic tx_valid;
	logic [7:0] tx_data;
	logic tx_ready;

	uart_rx #(.clks_per_bit(clks_per_bit)) uart_rx_inst (
		.clock      (clock),
		.reset_n    (reset_n),
		.rx         (rx),
		.byte_ready (byte_ready),
		.byte_data  (byte_data)
	);

	command_decoder command_decoder_inst (
		.clock        (clock),
		.reset_n      (reset_n),
		.byte_ready   (byte_ready),
		.byte_data    (byte_data),
		.cmd_received (cmd_received),
		.cmd          (cmd)
	);

	sump_control sump_control_inst (
		.clock         (clock),
		.reset_n       (reset_n),
		.cmd_received  (cmd_received),
		.cmd           (cmd),
		.probe         (probe),
		.tx_ready      (tx_ready),
		.tx_valid      (tx_valid),
		.tx_data       (tx_data),
		.armed         (armed),
		.triggered     (triggered),
		.divider       (divider),
		.trigger_mask  (trigger_mask),
		.trigger_value (trigger_value)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) uart_tx_inst (
		.clock    (clock),
		.reset_n  (reset_n),
		.tx_valid (tx_valid),
		.tx_data  (tx_data),
		.tx_ready (tx_ready),
		.tx       (tx)
	);

endmodule

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx #(
	parameter int clks_per_bit = 4
) (
	input  logic       clock,
	input  logic       reset_n,
	input  logic       rx,
	output logic       byte_ready,
	output logic [7:0] byte_data
);
	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] half_cnt = cnt_w'((clks_per_bit / 2) - 1);
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [cnt_w-1:0] count;
	logic [2:0] bit_cnt;

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			rx_meta <= 1'b1; // Line idles high
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			state      <= rx_idle;
			count      <= '0;
			bit_cnt    <= '0;
			byte_data  <= '0;
			byte_ready <= 1'b0;
		end else begin
			byte_ready <= 1'b0;
			case (state)
				rx_idle: begin
					count   <= '0;
					bit_cnt <= '0;
					if (!rx_sync) begin // Falling edge of start bit
						state <= rx_start;
					end
				end
				rx_start: begin
					count <= count + 1'b1;
					if (count == half_cnt) begin
						count <= '0;
						state <= rx_sync ? rx_idle : rx_data; // Glitch, not a start bit
					end
				end
				rx_data: begin
					count <= count + 1'b1;
					if (count == last_cnt) begin
						count     <= '0;
						byte_data <= {rx_sync, byte_data[7:1]}; // LSB first
						bit_cnt   <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= rx_stop;
						end
					end
				end
				rx_stop: begin
					count <= count + 1'b1;
					if (count == last_cnt) begin
						byte_ready <= rx_sync; // Framing error drops the byte
						state      <= rx_idle;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx #(
	parameter int clks_per_bit = 4
) (
	input  logic       clock,
	input  logic       reset_n,
	input  logic       tx_valid,
	input  logic [7:0] tx_data,
	output logic       tx_ready,
	output logic       tx
);
	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

	typedef enum logic [1:0] {tx_idle, tx_start, tx_data_bits, tx_stop} tx_state_t;

	tx_state_t state;
	logic [cnt_w-1:0] count;
	logic [2:0] bit_cnt;
	logic [7:0] shift;

	assign tx_ready = (state == tx_idle);

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			state   <= tx_idle;
			count   <= '0;
			bit_cnt <= '0;
			shift   <= '0;
			tx      <= 1'b1;
		end else begin
			count <= count + 1'b1;
			case (state)
				tx_idle: begin
					count <= '0;
					if (tx_valid) begin
						shift <= tx_data;
						tx    <= 1'b0; // Start bit
						state <= tx_start;
					end
				end
				tx_start: begin
					if (count == last_cnt) begin
						count   <= '0;
						bit_cnt <= '0;
						tx      <= shift[0];
						shift   <= {1'b0, shift[7:1]};
						state   <= tx_data_bits;
					end
				end
				tx_data_bits: begin
					if (count == last_cnt) begin
						count <= '0;
						if (bit_cnt == 3'd7) begin
							tx    <= 1'b1; // Stop bit
							state <= tx_stop;
						end else begin
							tx      <= shift[0];
							shift   <= {1'b0, shift[7:1]};
							bit_cnt <= bit_cnt + 3'd1;
						end
					end
				end
				tx_stop: begin
					if (count == last_cnt) begin
						state <= tx_idle;
					end
				end
				default: state <= tx_idle;
			endcase
		end
	end

endmodule

// ==== sim.f ====
hdl/sump_pkg.sv
hdl/uart_rx.sv
hdl/command_shift.sv
hdl/command_decoder.sv
hdl/sump_control.sv
hdl/uart_tx.sv
hdl/sump_top.sv
tb/sump_top_assert.sv
tb/sump_top_tb.sv

// ==== tb/sump_top_assert.sv ====
`timescale 1ns/1ns

module sump_top_assert (
	input logic       clock,
	input logic       reset_n,
	input logic       cmd_received,
	input logic       tx_valid,
	input logic       tx_ready,
	input logic [7:0] tx_data,
	input logic       armed,
	input logic       triggered
);
	int failures = 0;

	cmd_pulse: assert property (@(posedge clock) disable iff (!reset_n)
		cmd_received |=> !cmd_received)
	else begin
		failures++;
		$error("cmd_received high for two cycles in a row");
	end

	// Byte under back-pressure must not change
	tx_hold: assert property (@(posedge clock) disable iff (!reset_n)
		(tx_valid && !tx_ready) |=> $stable(tx_data))
	else begin
		failures++;
		$error("tx_data changed while waiting for tx_ready");
	end

	flags_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
		!(armed && triggered))
	else begin
		failures++;
		$error("armed and triggered both high");
	end

endmodule

bind sump_top sump_top_assert sump_top_assert_inst (
	.clock        (clock),
	.reset_n      (reset_n),
	.cmd_received (cmd_received),
	.tx_valid     (tx_valid),
	.tx_ready     (tx_ready),
	.tx_data      (tx_data),
	.armed        (armed),
	.triggered    (triggered)
);

// ==== tb/sump_top_tb.sv ====
`timescale 1ns/1ns

module sump_top_tb;
	localparam int clks_per_bit = 4;
	localparam int settle_cycles = 30;
	localparam int start_timeout = 200; // Cycles allowed before a reply byte starts
	localparam int num_entries = 9;

	typedef struct packed {
		logic        send; // Clear for a probe change only
		logic [7:0]  opcode;
		logic [31:0] payload;
		logic [7:0]  probe;
		logic [23:0] divider;
		logic [7:0]  mask;
		logic [7:0]  value;
		logic        armed;
		logic        triggered;
	} entry_t;

	logic clock;
	logic reset_n;
	logic rx;
	logic tx;
	logic [7:0] probe;
	logic armed;
	logic triggered;
	logic [23:0] divider;
	logic [7:0] trigger_mask;
	logic [7:0] trigger_value;

	entry_t cmd_table [0:num_entries-1];
	logic [31:0] rng_state;
	logic [7:0] reply [0:3];

	sump_top #(.clks_per_bit(clks_per_bit)) sump_top_inst (
		.clock         (clock),
		.reset_n       (reset_n),
		.rx            (rx),
		.tx            (tx),
		.probe         (probe),
		.armed         (armed),
		.triggered     (triggered),
		.divider       (divider),
		.trigger_mask  (trigger_mask),
		.trigger_value (trigger_value)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic entry_t make_entry(input logic send, input logic [7:0] opcode,
		input logic [31:0] payload, input logic [7:0] probe_val, input logic [23:0] div,
		input logic [7:0] mask, input logic [7:0] value, input logic arm, input logic trig);
		return {send, opcode, payload, probe_val, div, mask, value, arm, trig};
	endfunction

	task automatic stop_on_failure(input string line);
		$display("%s", line);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else
			stop_on_failure($sformatf("error at %0t ns: %s is %0h, expected %0h",
				$time, name, got, expected));
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#5;
	endtask

	// 8N1 frame sent LSB first
	task automatic send_byte(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx = frame[i];
			repeat (clks_per_bit) next_cycle();
		end
	endtask

	task automatic send_command(input logic [7:0] opcode, input logic [31:0] payload);
		send_byte(opcode);
		if (opcode[7]) begin
			for (int i = 3; i >= 0; i--) begin
				send_byte(payload[8 * i +: 8]); // Most significant byte first
			end
		end
	endtask

	task automatic receive_byte(input int timeout, output logic [7:0] data);
		int waited;
		waited = 0;
		while (tx !== 1'b0) begin
			if (waited == timeout) begin
				stop_on_failure("Timed out waiting for a start bit on tx");
			end
			waited++;
			next_cycle();
		end
		repeat (clks_per_bit / 2) next_cycle(); // Middle of the start bit
		assert (tx === 1'b0) else
			stop_on_failure($sformatf("error at %0t ns: start bit on tx is not low", $time));
		for (int i = 0; i < 8; i++) begin
			repeat (clks_per_bit) next_cycle();
			data[i] = tx;
		end
		repeat (clks_per_bit) next_cycle();
		assert (tx === 1'b1) else
			stop_on_failure($sformatf("error at %0t ns: stop bit on tx is not high", $time));
	endtask

	task automatic expect_tx_idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			next_cycle();
			assert (tx === 1'b1) else
				stop_on_failure($sformatf("error at %0t ns: extra byte started on tx", $time));
		end
	endtask

	task automatic build_table();
		logic [31:0] p;
		logic [23:0] div;
		logic [7:0] mask;
		logic [7:0] value;
		rng_state = 32'h5b82401d;
		rng_state = xorshift(rng_state);
		div = rng_state[23:0]; // Divider view drops the first byte
		cmd_table[0] = make_entry(1, sump_pkg::OP_SET_DIVIDER, rng_state, 0, div, 0, 0, 0, 0);
		rng_state = xorshift(rng_state);
		p = rng_state | 32'h1; // Keeps one mask bit set
		mask = p[7:0];
		cmd_table[1] = make_entry(1, sump_pkg::OP_TRIGGER_MASK, p, 0, div, mask, 0, 0, 0);
		rng_state = xorshift(rng_state);
		value = rng_state[7:0];
		cmd_table[2] = make_entry(1, sump_pkg::OP_TRIGGER_VALUE, rng_state, 0, div, mask,
			value, 0, 0);
		cmd_table[3] = make_entry(1, sump_pkg::OP_ARM, 0, value ^ 8'h01, div, mask, value, 1, 0);
		cmd_table[4] = make_entry(0, 8'h00, 0, value ^ ~mask, div, mask, value, 0, 1);
		cmd_table[5] = make_entry(1, sump_pkg::OP_RESET, 0, value ^ ~mask, div, mask, value, 0, 0);
		cmd_table[6] = make_entry(1, 8'h05, 0, 0, div, mask, value, 0, 0);
		rng_state = xorshift(rng_state);
		cmd_table[7] = make_entry(1, 8'ha5, rng_state, 0, div, mask, value, 0, 0);
		rng_state = xorshift(rng_state);
		cmd_table[8] = make_entry(1, sump_pkg::OP_SET_DIVIDER, rng_state, 0, rng_state[23:0],
			mask, value, 0, 0);
	endtask

	task automatic apply_entry(input int index, input entry_t e);
		probe = e.probe;
		if (e.send) begin
			send_command(e.opcode, e.payload);
		end
		repeat (settle_cycles) next_cycle();
		check_value($sformatf("entry %0d divider", index), divider, e.divider);
		check_value($sformatf("entry %0d trigger_mask", index), trigger_mask, e.mask);
		check_value($sformatf("entry %0d trigger_value", index), trigger_value, e.value);
		check_value($sformatf("entry %0d armed", index), armed, e.armed);
		check_value($sformatf("entry %0d triggered", index), triggered, e.triggered);
	endtask

	always @(posedge clock) begin
		assert (sump_top_inst.sump_top_assert_inst.failures == 0) else
			stop_on_failure("A concurrent assertion bound to sump_top failed");
	end

	initial begin
		rx = 1'b1;
		probe = 8'h00;
		reset_n = 1'b0;
		build_table();
		repeat (8) @(posedge clock);
		#5;
		reset_n = 1'b1;
		check_value("tx after reset", tx, 1'b1);
		check_value("armed after reset", armed, 1'b0);
		check_value("divider after reset", divider, 24'h0);
		for (int i = 0; i < num_entries; i++) begin
			apply_entry(i, cmd_table[i]);
		end
		send_byte(sump_pkg::OP_ID);
		fork
			begin
				for (int i = 0; i < 4; i++) begin
					receive_byte(start_timeout, reply[i]);
				end
			end
			send_byte(sump_pkg::OP_ID); // Arrives while the reply is running
		join
		for (int i = 0; i < 4; i++) begin
			check_value($sformatf("reply byte %0d", i), reply[i],
				sump_pkg::ID_WORD[31 - 8 * i -: 8]);
		end
		expect_tx_idle(20 * clks_per_bit);
		if (sump_top_inst.sump_top_assert_inst.failures == 0) begin
			$display("No errors");
			$finish;
		end else begin
			stop_on_failure("A concurrent assertion bound to sump_top failed");
		end
	end

endmodule
